// ==== periph_macros.svh ====
// shared widths, timer count and page numbers for the peripheral bus
// include wherever one of these values is needed

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// bus widths
`define PERI_DAT_WIDTH   32
`define PERI_ADR_WIDTH   30
`define PERI_SEL_WIDTH   (`PERI_DAT_WIDTH / 8)

// number of timers, 1 to 7
`define PERI_TIMER_NUM   3

// timers plus one external line
`define PERI_IRQ_NUM     (`PERI_TIMER_NUM + 1)

// byte address bits 31:28 of the peripheral region
`define PERI_REGION      4'hf

// page numbers, byte address bits 27:24
`define PERI_PAGE_IRC    0
`define PERI_PAGE_TIMER  1

`endif

// ==== periph_pkg.sv ====
// types shared by the peripheral bus blocks
// wishbone classic single-cycle request and response bundles

`include "periph_macros.svh"

package periph_pkg;

	// master to slave
	typedef struct packed
	{
		logic [`PERI_ADR_WIDTH-1:0] adr;
		logic [`PERI_DAT_WIDTH-1:0] dat;
		logic                       we;
		logic [`PERI_SEL_WIDTH-1:0] sel;
		logic                       stb;
	} wb_req_t;

	// slave to master
	typedef struct packed
	{
		logic [`PERI_DAT_WIDTH-1:0] dat;
		logic                       ack;
	} wb_rsp_t;

endpackage

// ==== periph_decoder.sv ====
// peripheral bus page decoder
// routes the strobe to the interrupt controller or one timer page
// and returns the selected slave's response; misses ack at once

`timescale 1ns/1ns

`include "periph_macros.svh"

module periph_decoder
	(
		input  periph_pkg::wb_req_t req_i,
		output periph_pkg::wb_rsp_t rsp_o,

		output periph_pkg::wb_req_t irc_req_o,
		input  periph_pkg::wb_rsp_t irc_rsp_i,

		output periph_pkg::wb_req_t tmr_req_o [`PERI_TIMER_NUM],
		input  periph_pkg::wb_rsp_t tmr_rsp_i [`PERI_TIMER_NUM]
	);

	// byte address 31:28 and 27:24
	logic [3:0] region;
	logic [3:0] page;

	assign region = req_i.adr[`PERI_ADR_WIDTH-1 -: 4];
	assign page   = req_i.adr[`PERI_ADR_WIDTH-5 -: 4];

	// ----------------------------------------
	//  strobe fan-out and response mux
	// ----------------------------------------

	always_comb
	begin
		// every slave sees the request, strobes stay low
		irc_req_o     = req_i;
		irc_req_o.stb = 1'b0;
		for (int i = 0; i < `PERI_TIMER_NUM; i++)
		begin
			tmr_req_o[i]     = req_i;
			tmr_req_o[i].stb = 1'b0;
		end

		// miss: zero data, same-cycle ack
		rsp_o.dat = '0;
		rsp_o.ack = req_i.stb;

		if (region == `PERI_REGION)
		begin
			if (page == 4'(`PERI_PAGE_IRC))
			begin
				irc_req_o.stb = req_i.stb;
				rsp_o         = irc_rsp_i;
			end

			for (int i = 0; i < `PERI_TIMER_NUM; i++)
			begin
				if (page == 4'(`PERI_PAGE_TIMER + i))
				begin
					tmr_req_o[i].stb = req_i.stb;
					rsp_o            = tmr_rsp_i[i];
				end
			end
		end
	end

endmodule

// ==== periph_timer.sv ====
// compare-match timer on one peripheral page
// reg 0 control (bit 0 enable, bit 1 clear), reg 1 compare, reg 2 counter
// irq_o is high for the cycle in which the counter equals compare

`timescale 1ns/1ns

`include "periph_macros.svh"

module periph_timer
	(
		input  logic                clk_i,
		input  logic                arst_n_i,

		input  periph_pkg::wb_req_t req_i,
		output periph_pkg::wb_rsp_t rsp_o,

		output logic                irq_o
	);

	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_CMP  = 2'd1;
	localparam logic [1:0] REG_CNT  = 2'd2;

	logic                       en_q;
	logic [`PERI_DAT_WIDTH-1:0] cmp_q;
	logic [`PERI_DAT_WIDTH-1:0] cnt_q;
	logic                       ack_q;
	logic [`PERI_DAT_WIDTH-1:0] rdata_q;

	logic                       acc;
	logic                       wr_en;
	logic                       clr;
	logic                       match;

	// accept once per strobe, ack never back to back
	assign acc   = req_i.stb & ~ack_q;
	assign wr_en = acc & req_i.we;
	assign clr   = wr_en && (req_i.adr[1:0] == REG_CTRL) && req_i.sel[0] && req_i.dat[1];
	assign match = en_q && (cnt_q == cmp_q);

	// ----------------------------------------
	//  registers and counter
	// ----------------------------------------

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			en_q  <= 1'b0;
			cmp_q <= '0;
			cnt_q <= '0;
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= acc;

			if (wr_en && (req_i.adr[1:0] == REG_CTRL) && req_i.sel[0])
				en_q <= req_i.dat[0];

			if (wr_en && (req_i.adr[1:0] == REG_CMP))
			begin
				for (int b = 0; b < `PERI_SEL_WIDTH; b++)
				begin
					if (req_i.sel[b])
						cmp_q[b*8 +: 8] <= req_i.dat[b*8 +: 8];
				end
			end

			// clear beats the compare wrap
			if (clr || match)
				cnt_q <= '0;
			else if (en_q)
				cnt_q <= cnt_q + 1'b1;
		end
	end

	// read data captured with the ack
	always_ff @(posedge clk_i)
	begin
		if (acc)
		begin
			case (req_i.adr[1:0])
				REG_CTRL: rdata_q <= {{(`PERI_DAT_WIDTH-1){1'b0}}, en_q};
				REG_CMP:  rdata_q <= cmp_q;
				REG_CNT:  rdata_q <= cnt_q;
				default:  rdata_q <= '0;
			endcase
		end
	end

	assign rsp_o.dat = rdata_q;
	assign rsp_o.ack = ack_q;
	assign irq_o     = match;

endmodule

// ==== periph_irc.sv ====
// interrupt controller for the timer pulses and one external line
// reg 0 global enable, reg 1 mask, reg 2 pending (write 1 to clear),
// reg 3 current factor with valid in bit 31; lowest source wins

`timescale 1ns/1ns

`include "periph_macros.svh"

module periph_irc
	(
		input  logic                     clk_i,
		input  logic                     arst_n_i,

		input  periph_pkg::wb_req_t      req_i,
		output periph_pkg::wb_rsp_t      rsp_o,

		input  logic [`PERI_IRQ_NUM-1:0] src_irq_i,

		output logic                     cpu_irq_o,
		input  logic                     cpu_irq_ack_i
	);

	localparam int unsigned N     = `PERI_IRQ_NUM;
	localparam int unsigned FID_W = $clog2(N);

	localparam logic [1:0] REG_GEN  = 2'd0;
	localparam logic [1:0] REG_MASK = 2'd1;
	localparam logic [1:0] REG_PEND = 2'd2;
	localparam logic [1:0] REG_FACT = 2'd3;

	logic                       gen_q;
	logic [N-1:0]               mask_q;
	logic [N-1:0]               pend_q;
	logic                       irq_q;
	logic                       ack_q;
	logic [`PERI_DAT_WIDTH-1:0] rdata_q;

	logic                       acc;
	logic                       wr_en;
	logic [N-1:0]               bit_sel;
	logic [N-1:0]               active;
	logic [FID_W-1:0]           fid;
	logic                       fvalid;
	logic [N-1:0]               pend_clr;
	logic [N-1:0]               pend_d;

	assign acc    = req_i.stb & ~ack_q;
	assign wr_en  = acc & req_i.we;
	assign active = pend_q & mask_q;

	// byte select of each source bit
	always_comb
	begin
		for (int i = 0; i < N; i++)
			bit_sel[i] = req_i.sel[i/8];
	end

	// ----------------------------------------
	//  priority and pending update
	// ----------------------------------------

	// scan down so the lowest index is kept
	always_comb
	begin
		fid    = '0;
		fvalid = 1'b0;
		for (int i = N - 1; i >= 0; i--)
		begin
			if (active[i])
			begin
				fid    = FID_W'(i);
				fvalid = 1'b1;
			end
		end
	end

	always_comb
	begin
		pend_clr = '0;
		if (wr_en && (req_i.adr[1:0] == REG_PEND))
			pend_clr = req_i.dat[N-1:0] & bit_sel;
		if (cpu_irq_ack_i && fvalid)
			pend_clr = pend_clr | (N'(1) << fid);

		// a new pulse overrides a clear
		pend_d = (pend_q & ~pend_clr) | src_irq_i;
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			gen_q  <= 1'b0;
			mask_q <= '0;
			pend_q <= '0;
			irq_q  <= 1'b0;
			ack_q  <= 1'b0;
		end
		else
		begin
			ack_q  <= acc;
			pend_q <= pend_d;
			irq_q  <= gen_q & fvalid;

			if (wr_en && (req_i.adr[1:0] == REG_GEN) && req_i.sel[0])
				gen_q <= req_i.dat[0];

			if (wr_en && (req_i.adr[1:0] == REG_MASK))
				mask_q <= (mask_q & ~bit_sel) | (req_i.dat[N-1:0] & bit_sel);
		end
	end

	// ----------------------------------------
	//  read back
	// ----------------------------------------

	always_ff @(posedge clk_i)
	begin
		if (acc)
		begin
			case (req_i.adr[1:0])
				REG_GEN:  rdata_q <= {{(`PERI_DAT_WIDTH-1){1'b0}}, gen_q};
				REG_MASK: rdata_q <= {{(`PERI_DAT_WIDTH-N){1'b0}}, mask_q};
				REG_PEND: rdata_q <= {{(`PERI_DAT_WIDTH-N){1'b0}}, pend_q};
				REG_FACT: rdata_q <= {fvalid, {(`PERI_DAT_WIDTH-1-FID_W){1'b0}}, fid};
				default:  rdata_q <= '0;
			endcase
		end
	end

	assign rsp_o.dat = rdata_q;
	assign rsp_o.ack = ack_q;
	assign cpu_irq_o = irq_q;

endmodule

// ==== periph_top.sv ====
// peripheral subsystem top
// one page decoder, a row of identical timers and the interrupt
// controller; the Wishbone port faces the external master

`timescale 1ns/1ns

`include "periph_macros.svh"

module periph_top
	(
		input  logic                clk_i,
		input  logic                arst_n_i,

		input  periph_pkg::wb_req_t req_i,
		output periph_pkg::wb_rsp_t rsp_o,

		input  logic                ext_irq_i,

		output logic                cpu_irq_o,
		input  logic                cpu_irq_ack_i
	);

	periph_pkg::wb_req_t            irc_req;
	periph_pkg::wb_rsp_t            irc_rsp;
	periph_pkg::wb_req_t            tmr_req [`PERI_TIMER_NUM];
	periph_pkg::wb_rsp_t            tmr_rsp [`PERI_TIMER_NUM];

	logic [`PERI_TIMER_NUM-1:0]     tmr_irq;
	logic [`PERI_IRQ_NUM-1:0]       src_irq;

	// timers on the low sources, external line on top
	assign src_irq = {ext_irq_i, tmr_irq};

	// ----------------------------------------
	//  address decoder
	// ----------------------------------------

	periph_decoder
		i_decoder
			(
				.req_i          (req_i),
				.rsp_o          (rsp_o),
				.irc_req_o      (irc_req),
				.irc_rsp_i      (irc_rsp),
				.tmr_req_o      (tmr_req),
				.tmr_rsp_i      (tmr_rsp)
			);

	// ----------------------------------------
	//  timers
	// ----------------------------------------

	for (genvar g = 0; g < `PERI_TIMER_NUM; g++)
	begin : g_timer
		periph_timer
			i_timer
				(
					.clk_i      (clk_i),
					.arst_n_i   (arst_n_i),
					.req_i      (tmr_req[g]),
					.rsp_o      (tmr_rsp[g]),
					.irq_o      (tmr_irq[g])
				);
	end

	// ----------------------------------------
	//  interrupt controller
	// ----------------------------------------

	periph_irc
		i_irc
			(
				.clk_i          (clk_i),
				.arst_n_i       (arst_n_i),
				.req_i          (irc_req),
				.rsp_o          (irc_rsp),
				.src_irq_i      (src_irq),
				.cpu_irq_o      (cpu_irq_o),
				.cpu_irq_ack_i  (cpu_irq_ack_i)
			);

endmodule

// ==== periph_tb.sv ====
// self-checking testbench for the peripheral subsystem
// reads bus operations from periph_patterns.txt, runs them through the
// Wishbone port and checks read data, ack timing and the cpu interrupt line

`timescale 1ns/1ns

`include "periph_macros.svh"

module periph_tb;

	localparam int MAX_OPS   = 128;
	localparam int OP_CYCLES = 200;
	localparam int WAIT_MAX  = 60;

	typedef enum logic [3:0]
	{
		OP_WR, OP_RD, OP_LE, OP_POLL, OP_IRQ, OP_PIN, OP_ACK, OP_EXT, OP_BAD
	} op_t;

	// one line of the pattern file
	typedef struct packed
	{
		op_t                        op;
		logic [127:0]               name;
		logic [31:0]                addr;
		logic [`PERI_SEL_WIDTH-1:0] sel;
		logic [`PERI_DAT_WIDTH-1:0] data;
		logic [`PERI_DAT_WIDTH-1:0] exp;
	} pattern_t;

	logic                clk;
	logic                arst_n;
	periph_pkg::wb_req_t req;
	periph_pkg::wb_rsp_t rsp;
	logic                ext_irq;
	logic                cpu_irq;
	logic                cpu_irq_ack;

	pattern_t            patterns [MAX_OPS];
	int                  n_ops;
	int                  errors;
	int                  checks;

	periph_top periph_top_i
		(
			.clk_i          (clk),
			.arst_n_i       (arst_n),
			.req_i          (req),
			.rsp_o          (rsp),
			.ext_irq_i      (ext_irq),
			.cpu_irq_o      (cpu_irq),
			.cpu_irq_ack_i  (cpu_irq_ack)
		);

	always #10 clk = ~clk;

	// ----------------------------------------
	//  pattern file
	// ----------------------------------------

	function automatic op_t op_code(input string s);
		if (s == "wr") return OP_WR;
		if (s == "rd") return OP_RD;
		if (s == "le") return OP_LE;
		if (s == "poll") return OP_POLL;
		if (s == "irq") return OP_IRQ;
		if (s == "pin") return OP_PIN;
		if (s == "ack") return OP_ACK;
		if (s == "ext") return OP_EXT;
		return OP_BAD;
	endfunction

	task automatic load_patterns();
		int           fd;
		int           cnt;
		string        line;
		string        op_s;
		logic [127:0] name;
		logic [31:0]  addr;
		logic [31:0]  sel;
		logic [31:0]  data;
		logic [31:0]  exp;
		fd = $fopen("periph_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open periph_patterns.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && n_ops < MAX_OPS)
		begin
			if ($fgets(line, fd) == 0)
				break;
			// comment lines start with #
			if (line.len() == 0 || line[0] == "#")
				continue;
			cnt = $sscanf(line, "%s %s %h %h %h %h", op_s, name, addr, sel, data, exp);
			if (cnt == 6)
			begin
				patterns[n_ops].op   = op_code(op_s);
				patterns[n_ops].name = name;
				patterns[n_ops].addr = addr;
				patterns[n_ops].sel  = sel[`PERI_SEL_WIDTH-1:0];
				patterns[n_ops].data = data;
				patterns[n_ops].exp  = exp;
				n_ops++;
			end
			else if (cnt > 0)
			begin
				$display("malformed pattern line: %s", line);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	//  bus and check helpers
	// ----------------------------------------

	task automatic check_value(input logic [127:0] name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("FAILED %0s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// one Wishbone classic cycle, after a random idle gap
	// mapped pages ack one cycle after the strobe, misses at once
	task automatic bus_access(input logic [127:0] name, input logic [31:0] addr,
		input logic we, input logic [3:0] sel, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int unsigned gap;
		int unsigned waited;
		int unsigned exp_wait;
		logic [3:0]  page;
		page     = addr[27:24];
		exp_wait = 1;
		if (addr[31:28] == 4'hf && (page == 4'(`PERI_PAGE_IRC)
			|| (page >= `PERI_PAGE_TIMER && page < `PERI_PAGE_TIMER + `PERI_TIMER_NUM)))
			exp_wait = 2;
		gap = $urandom_range(3, 0);
		repeat (gap + 1) @(posedge clk);
		req.adr <= addr[31:2];
		req.dat <= wdata;
		req.we  <= we;
		req.sel <= sel;
		req.stb <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge clk);
			waited++;
		end
		while (!rsp.ack);
		rdata = rsp.dat;
		req.stb <= 1'b0;
		req.we  <= 1'b0;
		checks++;
		assert (waited == exp_wait)
		else
		begin
			$display("FAILED %0s ack latency: expected %0d, actual %0d",
				name, exp_wait, waited);
			errors++;
		end
		// strobe is low again, so the ack has to be gone
		@(posedge clk);
		checks++;
		assert (!rsp.ack)
		else
		begin
			$display("%0s: acknowledge stayed high for a second cycle", name);
			errors++;
		end
	endtask

	task automatic run_pattern(input pattern_t p);
		logic [31:0] rdata;
		logic [31:0] masked;
		int          tries;
		tries = 0;
		case (p.op)
			OP_WR:
				bus_access(p.name, p.addr, 1'b1, p.sel, p.data, rdata);
			OP_RD:
			begin
				bus_access(p.name, p.addr, 1'b0, p.sel, '0, rdata);
				check_value(p.name, p.exp, rdata);
			end
			OP_LE:
			begin
				bus_access(p.name, p.addr, 1'b0, p.sel, '0, rdata);
				checks++;
				assert (rdata <= p.exp)
				else
				begin
					$display("FAILED %0s: expected <= %h, actual %h", p.name, p.exp, rdata);
					errors++;
				end
			end
			OP_POLL:
			begin
				// data column is the bit mask
				do
				begin
					bus_access(p.name, p.addr, 1'b0, p.sel, '0, rdata);
					masked = rdata & p.data;
					tries++;
				end
				while (masked !== p.exp && tries < WAIT_MAX);
				check_value(p.name, p.exp, masked);
			end
			OP_IRQ:
			begin
				@(posedge clk);
				while (cpu_irq !== p.exp[0] && tries < WAIT_MAX)
				begin
					@(posedge clk);
					tries++;
				end
				check_value(p.name, p.exp, {31'b0, cpu_irq});
			end
			OP_PIN:
			begin
				@(posedge clk);
				check_value(p.name, p.exp, {31'b0, cpu_irq});
			end
			OP_ACK:
			begin
				@(posedge clk);
				cpu_irq_ack <= 1'b1;
				@(posedge clk);
				cpu_irq_ack <= 1'b0;
			end
			OP_EXT:
			begin
				@(posedge clk);
				ext_irq <= p.data[0];
			end
			default:
			begin
				$display("unknown operation in pattern %0s", p.name);
				errors++;
			end
		endcase
	endtask

	// ----------------------------------------
	//  main sequence and watchdog
	// ----------------------------------------

	initial
	begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		req         = '0;
		ext_irq     = 1'b0;
		cpu_irq_ack = 1'b0;
		n_ops       = 0;
		errors      = 0;
		checks      = 0;
		void'($urandom(71));
		load_patterns();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_ops; i++)
			run_pattern(patterns[i]);
		repeat (2) @(posedge clk);
		$display("errors: %0d, checks: %0d, patterns: %0d", errors, checks, n_ops);
		if (errors == 0 && n_ops > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// budget scales with the pattern count
	initial
	begin
		wait (n_ops > 0);
		repeat (n_ops * OP_CYCLES + 10) @(posedge clk);
		$display("timeout: the patterns did not finish within %0d cycles", n_ops * OP_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== periph_patterns.txt ====
# op name byte_addr sel(hex) data expected; ops wr rd le poll irq pin ack ext
# poll reads until (rdata & data) == expected, irq waits for cpu_irq == expected
wr   cmp_t0      f1000004 f 12345678 00000000
wr   cmp_t1      f2000004 f 0000abcd 00000000
wr   cmp_t2      f3000004 f cafef00d 00000000
wr   mask        f0000004 f 0000000f 00000000
rd   cmp_t0      f1000004 f 00000000 12345678
rd   cmp_t1      f2000004 f 00000000 0000abcd
rd   cmp_t2      f3000004 f 00000000 cafef00d
rd   mask        f0000004 f 00000000 0000000f
wr   cmp_t0_b1   f1000004 2 aabbccdd 00000000
rd   cmp_t0_b1   f1000004 f 00000000 1234cc78
wr   cmp_t2_b03  f3000004 9 11223344 00000000
rd   cmp_t2_b03  f3000004 f 00000000 11fef044
rd   unmap_zero  00000000 f 00000000 00000000
wr   unmap_wr_f7 f7000004 f ffffffff 00000000
rd   unmap_f7    f7000004 f 00000000 00000000
wr   unmap_wr_0  00000004 f ffffffff 00000000
rd   cmp_t0_keep f1000004 f 00000000 1234cc78
rd   mask_keep   f0000004 f 00000000 0000000f
wr   cmp_t1_9    f2000004 f 00000009 00000000
wr   en_t1       f2000000 1 00000001 00000000
poll pend_t1     f0000008 f 00000002 00000002
le   cnt_t1      f2000008 f 00000000 00000009
wr   clr_t1      f2000000 1 00000002 00000000
rd   cnt_t1_zero f2000008 f 00000000 00000000
wr   pend_clr    f0000008 f 0000000f 00000000
rd   pend_zero   f0000008 f 00000000 00000000
wr   cmp_t0_5    f1000004 f 00000005 00000000
wr   cmp_t2_7    f3000004 f 00000007 00000000
wr   mask_b2     f0000004 f 00000004 00000000
wr   gen_on      f0000000 1 00000001 00000000
wr   en_t0       f1000000 1 00000001 00000000
wr   en_t2       f3000000 1 00000001 00000000
poll fact_t2     f000000c f ffffffff 80000002
irq  irq_high    00000000 0 00000000 00000001
wr   gen_off     f0000000 1 00000000 00000000
rd   gen_rd      f0000000 f 00000000 00000000
pin  irq_gen_off 00000000 0 00000000 00000000
wr   dis_t0      f1000000 1 00000000 00000000
wr   dis_t2      f3000000 1 00000000 00000000
wr   mask_b02    f0000004 f 00000005 00000000
rd   pend_both   f0000008 f 00000000 00000005
wr   gen_on2     f0000000 1 00000001 00000000
irq  irq_high2   00000000 0 00000000 00000001
rd   fact_t0     f000000c f 00000000 80000000
ack  ack_t0      00000000 0 00000000 00000000
rd   pend_ack    f0000008 f 00000000 00000004
rd   fact_t2b    f000000c f 00000000 80000002
pin  irq_still   00000000 0 00000000 00000001
wr   pend_w1c    f0000008 f 00000004 00000000
irq  irq_low     00000000 0 00000000 00000000
rd   pend_none   f0000008 f 00000000 00000000
rd   fact_none   f000000c f 00000000 00000000
wr   mask_b3     f0000004 f 00000008 00000000
ext  ext_on      00000000 0 00000001 00000000
poll pend_ext    f0000008 f 00000008 00000008
rd   fact_ext    f000000c f 00000000 80000003
irq  irq_ext     00000000 0 00000000 00000001
ext  ext_off     00000000 0 00000000 00000000
wr   pend_clr2   f0000008 f 0000000f 00000000
rd   pend_end    f0000008 f 00000000 00000000
irq  irq_end     00000000 0 00000000 00000000

// ==== verilog.f ====
+incdir+.
periph_pkg.sv
periph_decoder.sv
periph_timer.sv
periph_irc.sv
periph_top.sv
periph_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the peripheral subsystem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module periph_tb

# pass only when the pass message shows up in the simulation output
sim:
	verilator --binary --timing --assert -f verilog.f --top-module periph_tb
	./obj_dir/Vperiph_tb | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
